// ==== mem_cases.txt ====
# Columns: op (W write, R read) addr data pc expected name, values in hex
# Reads ignore data, writes expect their own data echoed back

# Bank 1, upper half of the address space
W 8000 1234 0100 1234 b1_wr_base
R 8000 0000 0101 1234 b1_rd_base
W 80ff beef 0102 beef b1_wr_top
R 80ff 0000 0103 beef b1_rd_top
W c055 a5a5 0104 a5a5 b1_wr_mid
R c055 0000 0105 a5a5 b1_rd_mid

# Bank 2, lower half
W 0000 4321 0106 4321 b2_wr_base
R 0000 0000 0107 4321 b2_rd_base
W 00ff cafe 0108 cafe b2_wr_top
R 00ff 0000 0109 cafe b2_rd_top
W 7f3c 5a5a 010a 5a5a b2_wr_mid
R 7f3c 0000 010b 5a5a b2_rd_mid

# Same low bits in both banks
W 8020 1111 010c 1111 alias_wr_b1
W 0020 2222 010d 2222 alias_wr_b2
R 8020 0000 010e 1111 alias_rd_b1
R 0020 0000 010f 2222 alias_rd_b2
W 00aa 0f0f 0110 0f0f alias_wr_b2_first
W 80aa f0f0 0111 f0f0 alias_wr_b1_second
R 00aa 0000 0112 0f0f alias_rd_b2_kept
R 80aa 0000 0113 f0f0 alias_rd_b1_kept

# Overwrite a word
W 8000 9999 0114 9999 b1_overwrite
R 8000 0000 0115 9999 b1_rd_overwrite
W 0000 0001 0116 0001 b2_overwrite
R 0000 0000 0117 0001 b2_rd_overwrite

# Only the low 8 bits index a bank
W 8142 7777 0118 7777 b1_wr_wrap
R fe42 0000 0119 7777 b1_rd_wrap
W 0142 3333 011a 3333 b2_wr_wrap
R 7e42 0000 011b 3333 b2_rd_wrap

# Reads alternating banks
R 80ff 0000 011c beef b1_rd_again
R 00ff 0000 011d cafe b2_rd_again
R c055 0000 011e a5a5 b1_rd_again_mid
R 7f3c 0000 011f 5a5a b2_rd_again_mid

# All-zero and all-one data
W 8001 0000 0120 0000 b1_wr_zero
R 8001 0000 0121 0000 b1_rd_zero
W 0001 ffff 0122 ffff b2_wr_ones
R 0001 0000 0123 ffff b2_rd_ones

// ==== verilog.f ====
+incdir+.
mem_pkg.sv
sram_bank.sv
ram_controller.sv
mem_subsystem.sv
tb_mem_subsystem.sv

// ==== Makefile ====
# Verilator build and run of the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_subsystem
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
CASES     ?= mem_cases.txt
VFLAGS    ?= --binary --timing -j 0

FAIL_MSG := Checks failed
PASS_MSG := All checks passed

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard *.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(SIM_BIN) $(CASES)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG) || \
		! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module tb_mem_subsystem;

	import mem_pkg::*;

	localparam int MAX_CASES       = 64;
	localparam int RAND_PAIRS      = 24;
	localparam int RESET_CYCLES    = 16;
	localparam int CYCLES_PER_TEST = 20;
	localparam logic [31:0] LCG_SEED = 32'h5446_8385;

	logic       ram_work_done = 1'b0;
	logic       rst;
	mem_req_t   req;
	reg_value_t pc;
	logic       work_done;
	mem_value_t feedback;
	logic       ram1_need_to_work;
	logic       ram2_need_to_work;

	// Directed cases from the file
	logic       case_wr   [MAX_CASES];
	mem_addr_t  case_addr [MAX_CASES];
	mem_value_t case_data [MAX_CASES];
	reg_value_t case_pc   [MAX_CASES];
	mem_value_t case_exp  [MAX_CASES];
	string      case_name [MAX_CASES];
	int         n_cases;

	// Expected contents by bank and low address bits
	mem_value_t ref_mem [2][1 << `BANK_DEPTH_BITS];

	int          err_count    = 0;
	int          tests_run    = 0;
	int          tests_failed = 0;
	int          cycle_cnt    = 0;
	int          max_cycles   = 100000;
	logic [31:0] rand_state;

	mem_subsystem u_dut (
		.ram_work_done     (ram_work_done),
		.rst               (rst),
		.req               (req),
		.pc                (pc),
		.work_done         (work_done),
		.feedback          (feedback),
		.ram1_need_to_work (ram1_need_to_work),
		.ram2_need_to_work (ram2_need_to_work)
	);

	// 8 ns period
	always #4 ram_work_done = ~ram_work_done;

	always @(posedge ram_work_done) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= max_cycles) begin
			$display("Timeout after %0d cycles, an access never completed", cycle_cnt);
			$display("Checks failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("[FAIL] %0s expected %h actual %h", name, expected, actual);
			err_count++;
		end
	endtask

	task automatic close_test(input string name, input int errs_before);
		tests_run++;
		if (err_count != errs_before) begin
			tests_failed++;
			$display("test %0s: FAILED", name);
		end else begin
			$display("test %0s: ok", name);
		end
	endtask

	task automatic load_cases();
		int               fd;
		int               got;
		int               cnt;
		logic [8*120-1:0] line_buf;
		logic [8*40-1:0]  name_buf;
		logic [7:0]       op_c;
		mem_addr_t        addr;
		mem_value_t       data;
		reg_value_t       cpc;
		mem_value_t       exp_val;
		n_cases = 0;
		fd = $fopen("mem_cases.txt", "r");
		if (fd == 0) begin
			$display("Could not open mem_cases.txt for reading");
			err_count++;
		end else begin
			while (!$feof(fd) && n_cases < MAX_CASES) begin
				line_buf = '0;
				got = $fgets(line_buf, fd);
				cnt = $sscanf(line_buf, "%s %h %h %h %h %s",
					op_c, addr, data, cpc, exp_val, name_buf);
				// Comment and blank lines fall out here
				if (got > 0 && cnt == 6 && (op_c == "W" || op_c == "R")) begin
					case_wr[n_cases]   = (op_c == "W");
					case_addr[n_cases] = addr;
					case_data[n_cases] = data;
					case_pc[n_cases]   = cpc;
					case_exp[n_cases]  = exp_val;
					case_name[n_cases] = $sformatf("%0s", name_buf);
					n_cases++;
				end
			end
			$fclose(fd);
			if (n_cases == 0) begin
				$display("No usable cases found in mem_cases.txt");
				err_count++;
			end
		end
	endtask

	// Idle stage must never stall
	task automatic check_idle(input string name);
		int errs_before;
		errs_before = err_count;
		@(posedge ram_work_done);
		#1;
		req = '0;
		@(posedge ram_work_done);
		#1;
		check_value({name, " work_done"}, 32'd1, 32'(work_done));
		check_value({name, " ram1_need_to_work"}, 32'd0, 32'(ram1_need_to_work));
		check_value({name, " ram2_need_to_work"}, 32'd0, 32'(ram2_need_to_work));
		close_test(name, errs_before);
	endtask

	//////////////////////////////////////////////////
	// One access held until work_done
	//////////////////////////////////////////////////

	task automatic run_access(input string name, input logic wr, input mem_addr_t addr,
		input mem_value_t data, input reg_value_t acc_pc, input mem_value_t expected);
		int       errs_before;
		int       cycles;
		int       exp_lat;
		logic     bank1;
		logic     sel_en;
		logic     other_en;
		mem_req_t r;
		errs_before = err_count;
		bank1 = addr[`MEM_ADDR_W-1];
		exp_lat = bank1 ? `BANK1_WAIT + 2 : `BANK2_WAIT + 2;
		cycles = 0;
		r.rd = !wr;
		r.wr = wr;
		r.addr = addr;
		r.data = data;
		@(posedge ram_work_done);
		#1;
		req = r;
		pc = acc_pc;
		#1;
		// Previous completion must not end this access
		check_value({name, " work_done at issue"}, 32'd0, 32'(work_done));
		do begin
			@(posedge ram_work_done);
			#1;
			cycles++;
			sel_en = bank1 ? ram1_need_to_work : ram2_need_to_work;
			other_en = bank1 ? ram2_need_to_work : ram1_need_to_work;
			check_value({name, " other bank enable"}, 32'd0, 32'(other_en));
			if (!work_done) begin
				check_value({name, " selected bank enable"}, 32'd1, 32'(sel_en));
			end
		end while (!work_done);
		check_value({name, " latency"}, exp_lat, cycles);
		check_value({name, " feedback"}, 32'(expected), 32'(feedback));
		close_test(name, errs_before);
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		int         i;
		mem_addr_t  r_addr;
		mem_value_t r_data;
		reg_value_t r_pc;
		rst = 1'b1;
		req = '0;
		pc = '0;
		rand_state = LCG_SEED;
		load_cases();
		max_cycles = (n_cases + 3 * RAND_PAIRS + 2) * CYCLES_PER_TEST + RESET_CYCLES;

		repeat (RESET_CYCLES) @(posedge ram_work_done);
		#1;
		rst = 1'b0;
		check_idle("idle_after_reset");

		for (i = 0; i < n_cases; i++) begin
			if (case_wr[i]) begin
				ref_mem[case_addr[i][`MEM_ADDR_W-1]][case_addr[i][`BANK_DEPTH_BITS-1:0]] =
					case_data[i];
			end
			run_access(case_name[i], case_wr[i], case_addr[i], case_data[i], case_pc[i],
				case_exp[i]);
		end

		// Random pairs use pcs clear of the case file range
		r_pc = 16'h4000;
		for (i = 0; i < RAND_PAIRS; i++) begin
			rand_state = lcg_next(rand_state);
			r_addr = rand_state[31:16];
			rand_state = lcg_next(rand_state);
			r_data = rand_state[23:8];
			ref_mem[r_addr[`MEM_ADDR_W-1]][r_addr[`BANK_DEPTH_BITS-1:0]] = r_data;
			run_access($sformatf("rand_wr_%0d", i), 1'b1, r_addr, r_data, r_pc, r_data);
			r_pc = r_pc + 16'd1;
			run_access($sformatf("rand_rd_%0d", i), 1'b0, r_addr, 16'h0000, r_pc,
				ref_mem[r_addr[`MEM_ADDR_W-1]][r_addr[`BANK_DEPTH_BITS-1:0]]);
			r_pc = r_pc + 16'd1;
		end

		// Read every random address back once all pairs are written
		rand_state = LCG_SEED;
		for (i = 0; i < RAND_PAIRS; i++) begin
			rand_state = lcg_next(rand_state);
			r_addr = rand_state[31:16];
			rand_state = lcg_next(rand_state);
			run_access($sformatf("rand_rb_%0d", i), 1'b0, r_addr, 16'h0000, r_pc,
				ref_mem[r_addr[`MEM_ADDR_W-1]][r_addr[`BANK_DEPTH_BITS-1:0]]);
			r_pc = r_pc + 16'd1;
		end

		check_idle("idle_at_end");

		$display("Tests run %0d, passed %0d, failed %0d, errors %0d",
			tests_run, tests_run - tests_failed, tests_failed, err_count);
		if (err_count == 0 && tests_failed == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module mem_subsystem (
	input  wire                      ram_work_done,
	input  wire                      rst,
	input  wire mem_pkg::mem_req_t   req,
	input  wire mem_pkg::reg_value_t pc,
	output wire                      work_done,
	output wire mem_pkg::mem_value_t feedback,
	output wire                      ram1_need_to_work,
	output wire                      ram2_need_to_work
);

	import mem_pkg::*;

	// Controller to banks
	bank_cmd_t  ram1_cmd;
	bank_cmd_t  ram2_cmd;

	// Banks back to controller
	logic       ram1_work_done;
	logic       ram2_work_done;
	mem_value_t ram1_feedback;
	mem_value_t ram2_feedback;

	ram_controller u_ctrl (
		.ram_work_done     (ram_work_done),
		.rst               (rst),
		.req               (req),
		.pc                (pc),
		.ram1_work_done    (ram1_work_done),
		.ram1_feedback     (ram1_feedback),
		.ram2_work_done    (ram2_work_done),
		.ram2_feedback     (ram2_feedback),
		.ram1_need_to_work (ram1_need_to_work),
		.ram2_need_to_work (ram2_need_to_work),
		.ram1_cmd          (ram1_cmd),
		.ram2_cmd          (ram2_cmd),
		.work_done         (work_done),
		.feedback          (feedback)
	);

	//////////////////////////////////////////////////
	// Bank 1 holds the upper half of the address space
	//////////////////////////////////////////////////
	sram_bank #(
		.WAIT (`BANK1_WAIT)
	) u_ram1 (
		.ram_work_done (ram_work_done),
		.rst           (rst),
		.need_to_work  (ram1_need_to_work),
		.cmd           (ram1_cmd),
		.work_done     (ram1_work_done),
		.feedback      (ram1_feedback)
	);

	sram_bank #(
		.WAIT (`BANK2_WAIT)
	) u_ram2 (
		.ram_work_done (ram_work_done),
		.rst           (rst),
		.need_to_work  (ram2_need_to_work),
		.cmd           (ram2_cmd),
		.work_done     (ram2_work_done),
		.feedback      (ram2_feedback)
	);

endmodule

`default_nettype wire

// ==== ram_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module ram_controller (
	input  wire                      ram_work_done,
	input  wire                      rst,
	input  wire mem_pkg::mem_req_t   req,
	input  wire mem_pkg::reg_value_t pc,
	input  wire                      ram1_work_done,
	input  wire mem_pkg::mem_value_t ram1_feedback,
	input  wire                      ram2_work_done,
	input  wire mem_pkg::mem_value_t ram2_feedback,
	output logic                     ram1_need_to_work,
	output logic                     ram2_need_to_work,
	output mem_pkg::bank_cmd_t       ram1_cmd,
	output mem_pkg::bank_cmd_t       ram2_cmd,
	output logic                     work_done,
	output mem_pkg::mem_value_t      feedback
);

	import mem_pkg::*;

	// Request decode
	logic       access;
	logic       bank1_sel;
	bank_cmd_t  cmd;

	// Completion bookkeeping
	logic       pc_done;
	logic       pending;
	logic       bank_done;
	mem_value_t bank_word;
	reg_value_t done_pc;
	logic       done_valid;
	mem_value_t feedback_q;

	//////////////////////////////////////////////////
	// Address decode
	//////////////////////////////////////////////////

	// Top address bit picks the bank, bank 1 owns the upper half
	assign access    = req.rd | req.wr;
	assign bank1_sel = req.addr[`MEM_ADDR_W-1];

	// Both banks see the same command, only the enable differs
	always_comb begin
		cmd.wr    = req.wr;
		cmd.index = req.addr[`BANK_DEPTH_BITS-1:0];
		cmd.data  = req.data;
	end

	assign ram1_cmd = cmd;
	assign ram2_cmd = cmd;

	// Access for this pc already finished?
	assign pc_done = done_valid && (done_pc == pc);
	assign pending = access && !pc_done;

	// Enable stays up until a completion tagged with this pc is recorded
	assign ram1_need_to_work = pending && bank1_sel;
	assign ram2_need_to_work = pending && !bank1_sel;

	//////////////////////////////////////////////////
	// Completion capture
	//////////////////////////////////////////////////

	// Only the enabled bank's pulse counts
	assign bank_done = (ram1_need_to_work && ram1_work_done) ||
		(ram2_need_to_work && ram2_work_done);

	assign bank_word = bank1_sel ? ram1_feedback : ram2_feedback;

	always_ff @(posedge ram_work_done) begin
		if (rst) begin
			done_valid <= 1'b0;
		end else if (bank_done) begin
			done_valid <= 1'b1;
		end
	end

	// Tag and word of the last completed access
	always_ff @(posedge ram_work_done) begin
		if (bank_done) begin
			done_pc    <= pc;
			feedback_q <= bank_word;
		end
	end

	//////////////////////////////////////////////////
	// Result return
	//////////////////////////////////////////////////

	// An idle stage is never stalled
	assign work_done = !access || pc_done;
	assign feedback  = feedback_q;

endmodule

`default_nettype wire

// ==== sram_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module sram_bank #(
	parameter int unsigned WAIT = 0
) (
	input  wire                     ram_work_done,
	input  wire                     rst,
	input  wire                     need_to_work,
	input  wire mem_pkg::bank_cmd_t cmd,
	output logic                    work_done,
	output mem_pkg::mem_value_t     feedback
);

	import mem_pkg::*;

	localparam int BANK_WORDS = 1 << `BANK_DEPTH_BITS;

	// Counter wide enough for WAIT-1, at least one bit
	localparam int CNT_W = (WAIT > 1) ? $clog2(WAIT) : 1;
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'((WAIT > 0) ? WAIT - 1 : 0);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAITING,
		ST_FINISH
	} bank_state_t;

	bank_state_t      state;
	logic [CNT_W-1:0] wait_cnt;

	// Word storage
	mem_value_t mem [BANK_WORDS];

	//////////////////////////////////////////////////
	// Wait-state FSM
	//////////////////////////////////////////////////

	always_ff @(posedge ram_work_done) begin
		if (rst) begin
			state    <= ST_IDLE;
			wait_cnt <= '0;
		end else if (!need_to_work) begin
			// Enable dropped, abandon any count in progress
			state    <= ST_IDLE;
			wait_cnt <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					wait_cnt <= '0;
					state    <= (WAIT == 0) ? ST_FINISH : ST_WAITING;
				end
				ST_WAITING: begin
					if (wait_cnt == LAST_CNT) begin
						state <= ST_FINISH;
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				ST_FINISH: begin
					// One-cycle done pulse, back to idle
					state <= ST_IDLE;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Access and result
	//////////////////////////////////////////////////

	// Write lands at the edge closing the finish cycle
	always_ff @(posedge ram_work_done) begin
		if (state == ST_FINISH && need_to_work && cmd.wr) begin
			mem[cmd.index] <= cmd.data;
		end
	end

	assign work_done = (state == ST_FINISH);

	// Writes echo their own data
	assign feedback = cmd.wr ? cmd.data : mem[cmd.index];

endmodule

`default_nettype wire

// ==== mem_pkg.sv ====
`default_nettype none

`include "mem_defs.svh"

package mem_pkg;

	// Plain words
	typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;
	typedef logic [`MEM_VALUE_W-1:0] mem_value_t;
	typedef logic [`REG_VALUE_W-1:0] reg_value_t;

	//////////////////////////////////////////////////
	// Request from the memory stage
	//////////////////////////////////////////////////
	typedef struct packed {
		logic       rd;
		logic       wr;
		mem_addr_t  addr;
		mem_value_t data;
	} mem_req_t;

	//////////////////////////////////////////////////
	// Command from the controller to one bank
	//////////////////////////////////////////////////
	typedef struct packed {
		logic                        wr;
		logic [`BANK_DEPTH_BITS-1:0] index;
		mem_value_t                  data;
	} bank_cmd_t;

endpackage

`default_nettype wire

// ==== mem_defs.svh ====
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

//////////////////////////////////////////////////
// Word widths of the memory stage
//////////////////////////////////////////////////

// Address and data word
`define MEM_ADDR_W 16
`define MEM_VALUE_W 16

// Program counter of the issuing instruction
`define REG_VALUE_W 16

//////////////////////////////////////////////////
// Bank geometry and timing
//////////////////////////////////////////////////

// Low address bits kept by each bank
`define BANK_DEPTH_BITS 8

// Wait cycles before a bank completes
`define BANK1_WAIT 2
`define BANK2_WAIT 4

`endif
